// ==== run_sim.sh ====
#!/bin/sh
# build the execute-stage testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f src.f --top-module ex_alu_tb --Mdir obj_dir -o ex_alu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ex_alu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
    exit 0
fi
exit 1

// ==== src.f ====
src/rv_data_pkg.sv
src/alu_op_pkg.sv
src/alu_addsub.sv
src/alu_bitops.sv
src/alu_mul_seq.sv
src/alu_div_seq.sv
src/alu_dispatcher.sv
src/ex_alu_top.sv
verif/ex_alu_tb.sv

// ==== src/alu_addsub.sv ====
// #########################################################
// alu_addsub
// add/subtract on one carry chain, with equal and
// signed/unsigned less-than flags from the subtraction
// #########################################################
module alu_addsub (
    input  logic [rv_data_pkg::XLEN-1:0] add_a,
    input  logic [rv_data_pkg::XLEN-1:0] add_b,
    input  logic                         sub,
    output logic [rv_data_pkg::XLEN-1:0] sum,
    output logic                         eq,
    output logic                         lt,
    output logic                         ltu
);

    logic [rv_data_pkg::XLEN-1:0] b_eff;
    logic [rv_data_pkg::XLEN:0]   full;

    // a - b as a + ~b + 1
    assign b_eff = sub ? ~add_b : add_b;
    assign full  = {1'b0, add_a} + {1'b0, b_eff} + sub;
    assign sum   = full[rv_data_pkg::XLEN-1:0];

    // flags only meaningful with sub set
    assign eq  = (sum == '0);
    assign ltu = !full[rv_data_pkg::XLEN];
    assign lt  = (add_a[rv_data_pkg::XLEN-1] != add_b[rv_data_pkg::XLEN-1]) ?
                 add_a[rv_data_pkg::XLEN-1] : sum[rv_data_pkg::XLEN-1];

endmodule

// ==== src/alu_bitops.sv ====
// #########################################################
// alu_bitops
// and/or/xor logic unit and a logarithmic barrel shifter
// #########################################################
module alu_bitops (
    input  logic [rv_data_pkg::XLEN-1:0]    bit_a,
    input  logic [rv_data_pkg::XLEN-1:0]    bit_b,
    input  logic [rv_data_pkg::SHAMT_W-1:0] shamt,
    input  alu_op_pkg::logic_op_e           logic_op,
    input  alu_op_pkg::shift_op_e           shift_op,
    output logic [rv_data_pkg::XLEN-1:0]    logic_res,
    output logic [rv_data_pkg::XLEN-1:0]    shift_res
);

    logic                                                  fill;
    logic [rv_data_pkg::XLEN-1:0]                          a_rev;
    logic [rv_data_pkg::XLEN-1:0]                          out_rev;
    logic [rv_data_pkg::SHAMT_W:0][rv_data_pkg::XLEN-1:0]  stage;

    always_comb begin
        case (logic_op)
            alu_op_pkg::LOG_AND: logic_res = bit_a & bit_b;
            alu_op_pkg::LOG_OR:  logic_res = bit_a | bit_b;
            default:             logic_res = bit_a ^ bit_b;
        endcase
    end

    // left shift reuses the right shifter on the reversed word
    assign a_rev    = {<<{bit_a}};
    assign fill     = (shift_op == alu_op_pkg::SH_RA) && bit_a[rv_data_pkg::XLEN-1];
    assign stage[0] = (shift_op == alu_op_pkg::SH_LL) ? a_rev : bit_a;

    for (genvar i = 0; i < rv_data_pkg::SHAMT_W; i++) begin : g_stage
        assign stage[i+1] = shamt[i] ?
            {{(2**i){fill}}, stage[i][rv_data_pkg::XLEN-1:2**i]} : stage[i];
    end

    assign out_rev   = {<<{stage[rv_data_pkg::SHAMT_W]}};
    assign shift_res = (shift_op == alu_op_pkg::SH_LL) ? out_rev : stage[rv_data_pkg::SHAMT_W];

endmodule

// ==== src/alu_dispatcher.sv ====
// #########################################################
// alu_dispatcher
// decodes the opcode, steers operands to the datapath units,
// sequences multiply/divide, registers the result and runs
// the input and output valid/ready handshakes
// #########################################################
module alu_dispatcher (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              in_valid,
    output logic                              in_ready,
    input  alu_op_pkg::alu_op_e               op,
    input  logic [rv_data_pkg::XLEN-1:0]      s1,
    input  logic [rv_data_pkg::XLEN-1:0]      s2,
    output logic                              out_valid,
    input  logic                              out_ready,
    output logic [rv_data_pkg::XLEN-1:0]      result,
    output logic                              branch_taken,
    // adder
    output logic [rv_data_pkg::XLEN-1:0]      add_a,
    output logic [rv_data_pkg::XLEN-1:0]      add_b,
    output logic                              sub,
    input  logic [rv_data_pkg::XLEN-1:0]      sum,
    input  logic                              eq,
    input  logic                              lt,
    input  logic                              ltu,
    // logic unit and shifter
    output logic [rv_data_pkg::XLEN-1:0]      bit_a,
    output logic [rv_data_pkg::XLEN-1:0]      bit_b,
    output logic [rv_data_pkg::SHAMT_W-1:0]   shamt,
    output alu_op_pkg::logic_op_e             logic_op,
    output alu_op_pkg::shift_op_e             shift_op,
    input  logic [rv_data_pkg::XLEN-1:0]      logic_res,
    input  logic [rv_data_pkg::XLEN-1:0]      shift_res,
    // multiplier
    output logic                              mul_start,
    output logic [rv_data_pkg::XLEN-1:0]      mul_a,
    output logic [rv_data_pkg::XLEN-1:0]      mul_b,
    output logic                              mul_neg,
    input  logic                              mul_done,
    input  logic [2*rv_data_pkg::XLEN-1:0]    mul_prod,
    // divider
    output logic                              div_start,
    output logic [rv_data_pkg::XLEN-1:0]      div_a,
    output logic [rv_data_pkg::XLEN-1:0]      div_b,
    output logic                              div_signed,
    input  logic                              div_done,
    input  logic [rv_data_pkg::XLEN-1:0]      quotient,
    input  logic [rv_data_pkg::XLEN-1:0]      remainder
);

    alu_op_pkg::ex_state_e          state;
    alu_op_pkg::alu_op_e            op_q;
    logic [rv_data_pkg::XLEN-1:0]   result_q;
    logic [rv_data_pkg::XLEN-1:0]   res_next;
    logic [rv_data_pkg::XLEN-1:0]   unit_res;
    logic                           taken_q;
    logic                           taken_next;
    logic                           is_mul;
    logic                           is_div;
    logic                           accept;
    logic                           s1_neg;
    logic                           s2_neg;

    assign is_mul = op inside {alu_op_pkg::ALU_MUL, alu_op_pkg::ALU_MULH,
                               alu_op_pkg::ALU_MULHSU, alu_op_pkg::ALU_MULHU};
    assign is_div = op inside {alu_op_pkg::ALU_DIV, alu_op_pkg::ALU_DIVU,
                               alu_op_pkg::ALU_REM, alu_op_pkg::ALU_REMU};

    // a multi-cycle op waits in HOLD until the old result drains
    assign in_ready = (state == alu_op_pkg::IDLE) ||
                      (state == alu_op_pkg::HOLD && out_ready && !(is_mul || is_div));
    assign accept   = in_valid && in_ready;

    assign mul_start = (state == alu_op_pkg::IDLE) && in_valid && is_mul;
    assign div_start = (state == alu_op_pkg::IDLE) && in_valid && is_div;

    // adder does compares by subtraction, and -s1 for the signed high multiplies
    always_comb begin
        add_a = s1;
        add_b = s2;
        sub   = 1'b1;
        case (op)
            alu_op_pkg::ALU_ADD: sub = 1'b0;
            alu_op_pkg::ALU_MULH,
            alu_op_pkg::ALU_MULHSU: begin
                add_a = '0;
                add_b = s1;
            end
            default: ;
        endcase
    end

    assign bit_a    = s1;
    assign bit_b    = s2;
    assign shamt    = s2[rv_data_pkg::SHAMT_W-1:0];
    assign logic_op = (op == alu_op_pkg::ALU_AND) ? alu_op_pkg::LOG_AND :
                      (op == alu_op_pkg::ALU_OR)  ? alu_op_pkg::LOG_OR  : alu_op_pkg::LOG_XOR;
    assign shift_op = (op == alu_op_pkg::ALU_SLL) ? alu_op_pkg::SH_LL :
                      (op == alu_op_pkg::ALU_SRL) ? alu_op_pkg::SH_RL : alu_op_pkg::SH_RA;

    // multiplier sees magnitudes only
    assign s1_neg  = s1[rv_data_pkg::XLEN-1] &&
                     (op == alu_op_pkg::ALU_MULH || op == alu_op_pkg::ALU_MULHSU);
    assign s2_neg  = s2[rv_data_pkg::XLEN-1] && (op == alu_op_pkg::ALU_MULH);
    assign mul_a   = s1_neg ? sum : s1;
    assign mul_b   = s2_neg ? -s2 : s2;
    assign mul_neg = s1_neg ^ s2_neg;

    assign div_a      = s1;
    assign div_b      = s2;
    assign div_signed = (op == alu_op_pkg::ALU_DIV) || (op == alu_op_pkg::ALU_REM);

    always_comb begin
        res_next   = '0;
        taken_next = 1'b0;
        case (op)
            alu_op_pkg::ALU_ADD, alu_op_pkg::ALU_SUB: res_next = sum;
            alu_op_pkg::ALU_AND, alu_op_pkg::ALU_OR, alu_op_pkg::ALU_XOR: res_next = logic_res;
            alu_op_pkg::ALU_SLL, alu_op_pkg::ALU_SRL, alu_op_pkg::ALU_SRA: res_next = shift_res;
            alu_op_pkg::ALU_SLT:    res_next = {{(rv_data_pkg::XLEN-1){1'b0}}, lt};
            alu_op_pkg::ALU_SLTU:   res_next = {{(rv_data_pkg::XLEN-1){1'b0}}, ltu};
            alu_op_pkg::ALU_BEQ:    taken_next = eq;
            alu_op_pkg::ALU_BNE:    taken_next = !eq;
            alu_op_pkg::ALU_BLT:    taken_next = lt;
            alu_op_pkg::ALU_BGE:    taken_next = !lt;
            alu_op_pkg::ALU_BLTU:   taken_next = ltu;
            alu_op_pkg::ALU_BGEU:   taken_next = !ltu;
            alu_op_pkg::ALU_COPY_A: res_next = s1;
            alu_op_pkg::ALU_COPY_B: res_next = s2;
            default: ;
        endcase
    end

    always_comb begin
        case (op_q)
            alu_op_pkg::ALU_MUL: unit_res = mul_prod[rv_data_pkg::XLEN-1:0];
            alu_op_pkg::ALU_MULH, alu_op_pkg::ALU_MULHSU, alu_op_pkg::ALU_MULHU:
                unit_res = mul_prod[2*rv_data_pkg::XLEN-1:rv_data_pkg::XLEN];
            alu_op_pkg::ALU_DIV, alu_op_pkg::ALU_DIVU: unit_res = quotient;
            default: unit_res = remainder;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= alu_op_pkg::IDLE;
        end else begin
            case (state)
                alu_op_pkg::IDLE:
                    if (in_valid)
                        state <= (is_mul || is_div) ? alu_op_pkg::WAIT_UNIT : alu_op_pkg::HOLD;
                alu_op_pkg::WAIT_UNIT:
                    if (mul_done || div_done)
                        state <= alu_op_pkg::HOLD;
                alu_op_pkg::HOLD:
                    if (out_ready && !accept)
                        state <= alu_op_pkg::IDLE;
                default: state <= alu_op_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            op_q <= op;
        if (accept && !(is_mul || is_div)) begin
            result_q <= res_next;
            taken_q  <= taken_next;
        end else if (state == alu_op_pkg::WAIT_UNIT && (mul_done || div_done)) begin
            result_q <= unit_res;
            taken_q  <= 1'b0;
        end
    end

    assign out_valid    = (state == alu_op_pkg::HOLD);
    assign result       = result_q;
    assign branch_taken = taken_q;

    // a started unit is always waited on, with no second start meanwhile
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (mul_start || div_start) |=>
            (state == alu_op_pkg::WAIT_UNIT && !mul_start && !div_start));

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(result) && $stable(branch_taken)));

endmodule

// ==== src/alu_div_seq.sv ====
// #########################################################
// alu_div_seq
// restoring divider, 32 iterations on magnitudes, then a
// sign fix-up cycle with RISC-V divide-by-zero behaviour
// #########################################################
module alu_div_seq (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             div_start,
    input  logic [rv_data_pkg::XLEN-1:0]     div_a,
    input  logic [rv_data_pkg::XLEN-1:0]     div_b,
    input  logic                             div_signed,
    output logic                             div_done,
    output logic [rv_data_pkg::XLEN-1:0]     quotient,
    output logic [rv_data_pkg::XLEN-1:0]     remainder
);

    logic [rv_data_pkg::XLEN-1:0]            q;
    logic [rv_data_pkg::XLEN-1:0]            r;
    logic [rv_data_pkg::XLEN-1:0]            d;
    logic [rv_data_pkg::XLEN:0]              r_sh;
    logic [rv_data_pkg::XLEN+1:0]            trial;
    logic                                    a_neg;
    logic                                    b_neg;
    logic                                    q_neg;
    logic                                    r_neg;
    logic                                    busy;
    logic                                    fin;
    logic [$clog2(rv_data_pkg::XLEN)-1:0]    cnt;

    assign a_neg = div_signed && div_a[rv_data_pkg::XLEN-1];
    assign b_neg = div_signed && div_b[rv_data_pkg::XLEN-1];

    // shift in the next dividend bit, try subtracting the divisor
    assign r_sh  = {r, q[rv_data_pkg::XLEN-1]};
    assign trial = {1'b0, r_sh} - {2'b0, d};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            fin      <= 1'b0;
            cnt      <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                busy <= 1'b1;
                fin  <= 1'b0;
                cnt  <= '0;
            end else if (busy && !fin) begin
                cnt <= cnt + 1'b1;
                if (&cnt)
                    fin <= 1'b1;
            end else if (busy) begin
                busy     <= 1'b0;
                fin      <= 1'b0;
                div_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            q     <= a_neg ? -div_a : div_a;
            d     <= b_neg ? -div_b : div_b;
            r     <= '0;
            // x/0 keeps the all-ones quotient whatever the dividend sign
            q_neg <= (a_neg ^ b_neg) && (div_b != '0);
            r_neg <= a_neg;
        end else if (busy && !fin) begin
            if (!trial[rv_data_pkg::XLEN+1]) begin
                r <= trial[rv_data_pkg::XLEN-1:0];
                q <= {q[rv_data_pkg::XLEN-2:0], 1'b1};
            end else begin
                r <= r_sh[rv_data_pkg::XLEN-1:0];
                q <= {q[rv_data_pkg::XLEN-2:0], 1'b0};
            end
        end else if (busy) begin
            q <= q_neg ? -q : q;
            r <= r_neg ? -r : r;
        end
    end

    assign quotient  = q;
    assign remainder = r;

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n) div_start |-> !busy);

endmodule

// ==== src/alu_mul_seq.sv ====
// #########################################################
// alu_mul_seq
// iterative shift-add multiplier over unsigned magnitudes,
// negating the 64-bit product in a last cycle when asked
// #########################################################
module alu_mul_seq (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             mul_start,
    input  logic [rv_data_pkg::XLEN-1:0]     mul_a,
    input  logic [rv_data_pkg::XLEN-1:0]     mul_b,
    input  logic                             mul_neg,
    output logic                             mul_done,
    output logic [2*rv_data_pkg::XLEN-1:0]   mul_prod
);

    logic [rv_data_pkg::XLEN-1:0]            mcand;
    logic [2*rv_data_pkg::XLEN-1:0]          prod;
    logic                                    neg_q;
    logic                                    busy;
    logic                                    fin;
    logic [$clog2(rv_data_pkg::XLEN)-1:0]    cnt;

    // one bit of the multiplier, product register shifts right
    function automatic logic [2*rv_data_pkg::XLEN-1:0] step(
        input logic [2*rv_data_pkg::XLEN-1:0] p,
        input logic [rv_data_pkg::XLEN-1:0]   m
    );
        logic [rv_data_pkg::XLEN:0] acc;
        acc = {1'b0, p[2*rv_data_pkg::XLEN-1:rv_data_pkg::XLEN]} + (p[0] ? {1'b0, m} : '0);
        return {acc, p[rv_data_pkg::XLEN-1:1]};
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            fin      <= 1'b0;
            cnt      <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= 1'b0;
            if (mul_start) begin
                busy <= 1'b1;
                fin  <= 1'b0;
                cnt  <= 1;
            end else if (busy && !fin) begin
                cnt <= cnt + 1'b1;
                if (&cnt)
                    fin <= 1'b1;
            end else if (busy) begin
                busy     <= 1'b0;
                fin      <= 1'b0;
                mul_done <= 1'b1;
            end
        end
    end

    // first iteration runs on the start edge
    always_ff @(posedge clk) begin
        if (mul_start) begin
            mcand <= mul_a;
            neg_q <= mul_neg;
            prod  <= step({{rv_data_pkg::XLEN{1'b0}}, mul_b}, mul_a);
        end else if (busy && !fin) begin
            prod <= step(prod, mcand);
        end else if (busy && neg_q) begin
            prod <= -prod;
        end
    end

    assign mul_prod = prod;

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n) mul_start |-> !busy);

endmodule

// ==== src/alu_op_pkg.sv ====
// #########################################################
// alu_op_pkg
// opcode, unit-control and dispatcher state encodings
// for the integer execute stage
// #########################################################
package alu_op_pkg;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        // branch compares, result word is zero
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_COPY_A, ALU_COPY_B,
        // multi-cycle ops
        ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
        ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
    } alu_op_e;

    typedef enum logic [1:0] {
        LOG_AND,
        LOG_OR,
        LOG_XOR
    } logic_op_e;

    typedef enum logic [1:0] {
        SH_LL,
        SH_RL,
        SH_RA
    } shift_op_e;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_UNIT,
        HOLD
    } ex_state_e;

endpackage

// ==== src/ex_alu_top.sv ====
// #########################################################
// ex_alu_top
// integer execute stage, dispatcher plus add/sub, logic and
// shift, multiply and divide units
// #########################################################
module ex_alu_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  alu_op_pkg::alu_op_e           op,
    input  logic [rv_data_pkg::XLEN-1:0]  s1,
    input  logic [rv_data_pkg::XLEN-1:0]  s2,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [rv_data_pkg::XLEN-1:0]  result,
    output logic                          branch_taken
);

    logic [rv_data_pkg::XLEN-1:0]         add_a;
    logic [rv_data_pkg::XLEN-1:0]         add_b;
    logic                                 sub;
    logic [rv_data_pkg::XLEN-1:0]         sum;
    logic                                 eq;
    logic                                 lt;
    logic                                 ltu;
    logic [rv_data_pkg::XLEN-1:0]         bit_a;
    logic [rv_data_pkg::XLEN-1:0]         bit_b;
    logic [rv_data_pkg::SHAMT_W-1:0]      shamt;
    alu_op_pkg::logic_op_e                logic_op;
    alu_op_pkg::shift_op_e                shift_op;
    logic [rv_data_pkg::XLEN-1:0]         logic_res;
    logic [rv_data_pkg::XLEN-1:0]         shift_res;
    logic                                 mul_start;
    logic [rv_data_pkg::XLEN-1:0]         mul_a;
    logic [rv_data_pkg::XLEN-1:0]         mul_b;
    logic                                 mul_neg;
    logic                                 mul_done;
    logic [2*rv_data_pkg::XLEN-1:0]       mul_prod;
    logic                                 div_start;
    logic [rv_data_pkg::XLEN-1:0]         div_a;
    logic [rv_data_pkg::XLEN-1:0]         div_b;
    logic                                 div_signed;
    logic                                 div_done;
    logic [rv_data_pkg::XLEN-1:0]         quotient;
    logic [rv_data_pkg::XLEN-1:0]         remainder;

    // port names match the wires above
    alu_dispatcher alu_dispatcher_i (.*);

    alu_addsub alu_addsub_i (.*);

    alu_bitops alu_bitops_i (.*);

    alu_mul_seq alu_mul_seq_i (.*);

    alu_div_seq alu_div_seq_i (.*);

endmodule

// ==== src/rv_data_pkg.sv ====
// #########################################################
// rv_data_pkg
// word and shift-amount widths of the execute datapath
// #########################################################
package rv_data_pkg;

    // RV32 data word
    localparam int XLEN = 32;

    // shift amount comes from the low bits of s2
    localparam int SHAMT_W = 5;

endpackage

// ==== verif/ex_alu_tb.sv ====
// #########################################################
// ex_alu_tb
// runs the execute stage through a file of tests under
// random output back-pressure, checks results in order
// #########################################################
module ex_alu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        alu_op_pkg::alu_op_e          op;
        logic [rv_data_pkg::XLEN-1:0] a;
        logic [rv_data_pkg::XLEN-1:0] b;
        logic [rv_data_pkg::XLEN-1:0] exp;
        logic                         taken;
    } test_t;

    logic                         clk;
    logic                         rst_n;
    logic                         in_valid;
    logic                         in_ready;
    alu_op_pkg::alu_op_e          op;
    logic [rv_data_pkg::XLEN-1:0] s1;
    logic [rv_data_pkg::XLEN-1:0] s2;
    logic                         out_valid;
    logic                         out_ready = 1'b0;
    logic [rv_data_pkg::XLEN-1:0] result;
    logic                         branch_taken;

    test_t       tests[$];
    int          errors = 0;
    int          checked = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    logic [31:0] rng = 32'ha9d1;

    ex_alu_top ex_alu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // file mnemonic to opcode, e.g. copy_a -> ALU_COPY_A
    function automatic bit decode_op(input string m, output alu_op_pkg::alu_op_e e);
        alu_op_pkg::alu_op_e k;
        string               want;
        want = {"ALU_", m.toupper()};
        k = k.first();
        e = k;
        for (int i = 0; i < k.num(); i++) begin
            if (k.name() == want) begin
                e = k;
                return 1'b1;
            end
            k = k.next();
        end
        return 1'b0;
    endfunction

    task automatic load_tests();
        int                           fd;
        int                           n;
        string                        line;
        string                        mnem;
        logic [rv_data_pkg::XLEN-1:0] a;
        logic [rv_data_pkg::XLEN-1:0] b;
        logic [rv_data_pkg::XLEN-1:0] exp;
        logic [31:0]                  tk;
        test_t                        t;
        fd = $fopen("verif/ex_alu_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/ex_alu_tests.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#")
                    continue;
                n = $sscanf(line, "%s %h %h %h %h", mnem, a, b, exp, tk);
                if (n != 5) begin
                    errors++;
                    $display("a line of the test file could not be read: %s", line);
                    continue;
                end
                if (!decode_op(mnem, t.op)) begin
                    errors++;
                    $display("unknown opcode %s in the test file", mnem);
                    continue;
                end
                t.a     = a;
                t.b     = b;
                t.exp   = exp;
                t.taken = tk[0];
                tests.push_back(t);
            end
            $fclose(fd);
        end
    endtask

    task automatic print_summary();
        $display("summary: %0d errors, %0d of %0d tests run", errors, checked, tests.size());
    endtask

    // random back-pressure that is low about one cycle in four
    always @(posedge clk) begin
        #1;
        rng = xorshift32(rng);
        out_ready = (rng[1:0] != 2'b00);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("simulation timed out before all results arrived");
            print_summary();
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic drive_tests();
        foreach (tests[i]) begin
            @(posedge clk);
            #1;
            in_valid = 1'b1;
            op       = tests[i].op;
            s1       = tests[i].a;
            s2       = tests[i].b;
            do
                @(negedge clk);
            while (!in_ready);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // sampled at the falling edge before the rising edge that transfers
    task automatic collect_results();
        logic [rv_data_pkg::XLEN-1:0] held;
        logic                         held_taken;
        bit                           holding;
        alu_op_pkg::alu_op_e          cur_op;
        holding = 1'b0;
        while (checked < tests.size()) begin
            @(negedge clk);
            cur_op = tests[checked].op;
            if (holding) begin
                assert (out_valid) else begin
                    errors++;
                    $display("out_valid dropped at %0t before the result was taken", $time);
                end
                assert (result == held && branch_taken == held_taken) else begin
                    errors++;
                    $display("Mismatch at %0t: %s held %h taken %b changed to %h taken %b",
                             $time, cur_op.name(), held, held_taken, result, branch_taken);
                end
            end
            holding = 1'b0;
            if (out_valid && out_ready) begin
                assert (result == tests[checked].exp &&
                        branch_taken == tests[checked].taken) else begin
                    errors++;
                    $display("Mismatch at %0t: %s got %h taken %b, expected %h taken %b",
                             $time, cur_op.name(), result, branch_taken,
                             tests[checked].exp, tests[checked].taken);
                end
                checked++;
            end else if (out_valid) begin
                holding    = 1'b1;
                held       = result;
                held_taken = branch_taken;
            end
        end
        repeat (4) begin
            @(negedge clk);
            assert (!out_valid) else begin
                errors++;
                $display("an extra result appeared at %0t after the last test", $time);
            end
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        op       = alu_op_pkg::ALU_ADD;
        s1       = '0;
        s2       = '0;
        load_tests();
        cycle_limit = 40 * tests.size() + 100;
        if (tests.size() == 0) begin
            $display("no tests were read from verif/ex_alu_tests.txt");
            $display("TB FAILED");
            $finish;
        end else begin
            repeat (3) @(posedge clk);
            #1;
            rst_n = 1'b1;
            @(negedge clk);
            assert (!out_valid && in_ready) else begin
                errors++;
                $display("Mismatch at %0t: after reset out_valid %b in_ready %b, expected 0 1",
                         $time, out_valid, in_ready);
            end
            fork
                drive_tests();
                collect_results();
            join
            print_summary();
            if (errors == 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== verif/ex_alu_tests.txt ====
# columns: opcode s1 s2 expected_result expected_taken
# all values in hex, one test per line, run in file order
add 00000005 00000007 0000000c 0
sub 00000003 00000005 fffffffe 0
and f0f0ff00 0ff0f0f0 00f0f000 0
or f0f0ff00 0ff0f0f0 fff0fff0 0
xor f0f0ff00 0ff0f0f0 ff000ff0 0
sll 00000001 0000001f 80000000 0
sll 12345678 00000000 12345678 0
sll 00000003 00000024 00000030 0
srl 80000000 0000001f 00000001 0
sra 80000000 0000001f ffffffff 0
sra f0000000 00000004 ff000000 0
slt ffffffff 00000001 00000001 0
sltu ffffffff 00000001 00000000 0
sltu 00000005 80000005 00000001 0
beq 00000007 00000007 00000000 1
bne 00000005 80000005 00000000 1
blt 80000005 00000005 00000000 1
bge 80000005 00000005 00000000 0
bge 00000005 00000005 00000000 1
bltu 80000005 00000005 00000000 0
bgeu 80000005 00000005 00000000 1
copy_a 11111111 22222222 11111111 0
copy_b 11111111 22222222 22222222 0
mul 00000003 00000007 00000015 0
mul 80000000 80000000 00000000 0
mulh 00010000 00010000 00000001 0
mulh fffffffe 00000003 ffffffff 0
mulh 00000003 fffffffe ffffffff 0
mulh 80000000 80000000 40000000 0
mulhsu ffffffff ffffffff ffffffff 0
mulhsu 00000002 80000000 00000001 0
mulhu ffffffff ffffffff fffffffe 0
div 00000014 00000006 00000003 0
div ffffffec 00000006 fffffffd 0
rem ffffffec 00000006 fffffffe 0
divu ffffffec 00000006 2aaaaaa7 0
remu ffffffec 00000006 00000002 0
div ffffff00 00000000 ffffffff 0
rem ffffff00 00000000 ffffff00 0
remu 00001234 00000000 00001234 0
div 80000000 ffffffff 80000000 0
rem 80000000 ffffffff 00000000 0
add 00000001 00000001 00000002 0
